//--- apb3_host.f
+incdir+.
apb3_host_pkg.sv
apb3_cmd_if.sv
apb3_cmd_queue.sv
apb3_wlm_host.sv
apb3_mem_slave.sv
apb3_host_top.sv
tb_apb3_host.sv

//--- Bender.yml
package:
  name: apb3_host

sources:
  - include_dirs:
      - .
    files:
      - apb3_host_pkg.sv
      - apb3_cmd_if.sv
      - apb3_cmd_queue.sv
      - apb3_wlm_host.sv
      - apb3_mem_slave.sv
      - apb3_host_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_apb3_host.sv

//--- tb_apb3_host.sv
// Self-checking bench for the APB3 host; stops at the first mismatch, bounded by a cycle limit
`default_nettype none

`include "apb3_host_settings.svh"

module tb_apb3_host import apb3_host_pkg::*; ();

  // Enough for about 230 commands at up to 8 cycles each, plus margin
  localparam int MAX_CYCLES = 230 * 8 + 200;

  // Expected response of one command
  typedef struct packed {
    logic     write;
    logic     error;
    apb_rsp_u word;
  } exp_rsp_t;

  logic               pclk;
  logic               reset;
  logic               cmd_push;
  logic               cmd_write;
  logic [`APB_AW-1:0] cmd_addr;
  logic [`APB_DW-1:0] cmd_wdata;
  logic               credit_return;
  logic               rsp_valid;
  logic               rsp_write;
  logic               rsp_error;
  apb_rsp_u           rsp_word;

  logic [`APB_DW-1:0] model_mem [`MEM_WORDS];
  exp_rsp_t           exp_q [$];
  exp_rsp_t           exp_cur;
  logic [31:0]        lcg_state;
  int                 credits;
  int                 cycle_cnt;
  int                 push_count;

  apb3_host_top dut_i (
    .pclk          (pclk),
    .reset         (reset),
    .cmd_push      (cmd_push),
    .cmd_write     (cmd_write),
    .cmd_addr      (cmd_addr),
    .cmd_wdata     (cmd_wdata),
    .credit_return (credit_return),
    .rsp_valid     (rsp_valid),
    .rsp_write     (rsp_write),
    .rsp_error     (rsp_error),
    .rsp_word      (rsp_word)
  );

  always #4 pclk = ~pclk;

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  task automatic check_rsp_word(input apb_rsp_u got, input apb_rsp_u exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_credits(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  // --------------------------------------------------
  // Reference model and random source
  // --------------------------------------------------

  // Numerical Recipes LCG constants
  function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Word address decides data or fault view
  function automatic exp_rsp_t ref_rsp(input logic write, input logic [31:0] addr,
                                       input logic [31:0] wdata);
    exp_rsp_t    e;
    logic [29:0] word;
    word    = addr[31:2];
    e.write = write;
    e.error = 1'b0;
    e.word  = '0;
    if (word >= `MEM_WORDS) begin
      // Out of range, memory untouched
      e.error                = 1'b1;
      e.word.fault.code      = 2'b01;
      e.word.fault.word_addr = word;
    end else if (write) begin
      model_mem[word] = wdata;
      e.word.data     = wdata;
    end else begin
      e.word.data = model_mem[word];
    end
    return e;
  endfunction

  // --------------------------------------------------
  // Driver helpers
  // --------------------------------------------------

  // Every wait goes through here so no credit pulse is missed
  task automatic next_cycle();
    @(negedge pclk);
    cmd_push = 1'b0;
    if (credit_return === 1'b1) begin
      credits++;
      // A spurious credit pushes the count past the queue depth
      if (credits > `CMD_DEPTH) begin
        check_credits(credits, `CMD_DEPTH, "credits above queue depth");
      end
    end
  endtask

  task automatic send_cmd(input logic write, input logic [31:0] addr, input logic [31:0] wdata);
    while (credits == 0) begin
      next_cycle();
    end
    cmd_push  = 1'b1;
    cmd_write = write;
    cmd_addr  = addr;
    cmd_wdata = wdata;
    credits--;
    push_count++;
    exp_q.push_back(ref_rsp(write, addr, wdata));
    next_cycle();
  endtask

  // Wait for every outstanding response
  task automatic drain();
    while (exp_q.size() != 0) begin
      next_cycle();
    end
    next_cycle();
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (5) begin
      next_cycle();
      check_flag(rsp_valid, 1'b0, "rsp_valid in reset");
      check_flag(credit_return, 1'b0, "credit_return in reset");
    end
    reset   = 1'b0;
    credits = `CMD_DEPTH;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      model_mem[i] = '0;
    end
  endtask

  // --------------------------------------------------
  // Response compare
  // --------------------------------------------------

  // Outputs move on the rising edge, so the falling edge sees them settled
  always @(negedge pclk) begin
    if (!reset && rsp_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("A response arrived with no command outstanding at %0t", $time);
        $display("TB FAILED");
        $fatal(1);
      end else begin
        exp_cur = exp_q.pop_front();
        check_flag(rsp_write, exp_cur.write, "rsp_write");
        check_flag(rsp_error, exp_cur.error, "rsp_error");
        check_rsp_word(rsp_word, exp_cur.word, "rsp_word");
      end
    end
  end

  // Watchdog
  always @(posedge pclk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] addr;
    pclk       = 1'b0;
    reset      = 1'b1;
    cmd_push   = 1'b0;
    cmd_write  = 1'b0;
    cmd_addr   = '0;
    cmd_wdata  = '0;
    lcg_state  = 32'hce48_fd11;
    credits    = `CMD_DEPTH;
    cycle_cnt  = 0;
    push_count = 0;
    apply_reset();

    // Never-written words read back as zero
    for (int i = 40; i < 44; i++) begin
      send_cmd(1'b0, i * 4, '0);
    end

    // Write then read back, one of each wait state
    for (int i = 0; i < 6; i++) begin
      send_cmd(1'b1, i * 4, rand_word());
    end
    for (int i = 0; i < 6; i++) begin
      send_cmd(1'b0, i * 4, '0);
    end

    // Out of range writes alias words 0..2 in the low bits
    for (int i = 0; i < 3; i++) begin
      send_cmd(1'b1, 32'h100 + i * 4, 32'hdead_0000 + i);
    end
    send_cmd(1'b0, 32'h3ffc_000c, '0);
    for (int i = 0; i < 3; i++) begin
      send_cmd(1'b0, i * 4, '0);
    end
    drain();
    check_credits(credits, `CMD_DEPTH, "credits after directed tests");

    // Burst on slow addresses until credits run out
    while (credits != 0) begin
      cmd_push  = 1'b1;
      cmd_write = 1'b0;
      cmd_addr  = 32'h0c + push_count * 16;
      cmd_wdata = '0;
      credits--;
      exp_q.push_back(ref_rsp(1'b0, cmd_addr, '0));
      push_count++;
      next_cycle();
    end
    drain();
    check_credits(credits, `CMD_DEPTH, "credits after burst drain");

    // Mixed random stream, about one in eight out of range
    // Kind, address and gap come from the upper LCG bits
    for (int n = 0; n < 200; n++) begin
      r = rand_word();
      if (r[30:28] == 3'd0) begin
        addr = {14'h0, r[27:12], 2'b00} | 32'h100;
      end else begin
        addr = {24'h0, r[21:16], 2'b00};
      end
      send_cmd(r[31], addr, rand_word());
      repeat (r[23:22]) begin
        next_cycle();
      end
    end
    drain();
    check_credits(credits, `CMD_DEPTH, "credits after random stream");

    // Memory must be cleared by a second reset
    send_cmd(1'b1, 32'h28, 32'ha5a5_5a5a);
    drain();
    apply_reset();
    send_cmd(1'b0, 32'h28, '0);
    drain();

    check_credits(credits, `CMD_DEPTH, "credits at end");
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- apb3_host_top.sv
// Source must start with `CMD_DEPTH credits and push only while holding one; responses cannot stall
`default_nettype none

`include "apb3_host_settings.svh"

module apb3_host_top import apb3_host_pkg::*; (
  input  logic               pclk,
  input  logic               reset,
  input  logic               cmd_push,
  input  logic               cmd_write,
  input  logic [`APB_AW-1:0] cmd_addr,
  input  logic [`APB_DW-1:0] cmd_wdata,
  output logic               credit_return,
  output logic               rsp_valid,
  output logic               rsp_write,
  output logic               rsp_error,
  output apb_rsp_u           rsp_word
);

  // --------------------------------------------------
  // Internal links
  // --------------------------------------------------

  apb3_cmd_if cmd_if ();

  apb_cmd_t           push_cmd;
  logic [`APB_AW-1:0] paddr;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [`APB_DW-1:0] pwdata;
  logic [`APB_DW-1:0] prdata;
  logic               pready;
  logic               pslverr;

  // Plain command ports packed into one struct
  assign push_cmd.write = cmd_write;
  assign push_cmd.addr  = cmd_addr;
  assign push_cmd.wdata = cmd_wdata;

  // --------------------------------------------------
  // Blocks
  // --------------------------------------------------

  apb3_cmd_queue queue_i (
    .pclk          (pclk),
    .reset         (reset),
    .push          (cmd_push),
    .push_cmd      (push_cmd),
    .credit_return (credit_return),
    .cmd           (cmd_if.queue)
  );

  apb3_wlm_host master (
    .pclk      (pclk),
    .reset     (reset),
    .cmd       (cmd_if.host),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .rsp_valid (rsp_valid),
    .rsp_write (rsp_write),
    .rsp_error (rsp_error),
    .rsp_word  (rsp_word)
  );

  // Single completer on the one select line
  apb3_mem_slave slave_i (
    .pclk    (pclk),
    .reset   (reset),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

endmodule

`default_nettype wire

//--- apb3_mem_slave.sv
// Word access only, paddr[1:0] ignored; wait states come from paddr[3:2], errors above `MEM_WORDS
`default_nettype none

`include "apb3_host_settings.svh"

module apb3_mem_slave (
  input  logic               pclk,
  input  logic               reset,
  input  logic [`APB_AW-1:0] paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [`APB_DW-1:0] pwdata,
  output logic [`APB_DW-1:0] prdata,
  output logic               pready,
  output logic               pslverr
);

  localparam int unsigned IW = $clog2(`MEM_WORDS);

  logic [`APB_DW-1:0] mem [`MEM_WORDS];
  logic [IW-1:0]      idx;
  logic               out_of_range;
  logic               setup;
  logic               access;
  logic [1:0]         wait_cnt;

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------

  assign idx          = paddr[IW+1:2];
  assign out_of_range = (paddr[`APB_AW-1:2] >= `MEM_WORDS);
  assign setup        = psel && !penable;
  assign access       = psel && penable;

  // Ready once the wait count has run out
  assign pready  = access && (wait_cnt == 2'd0);
  assign pslverr = pready && out_of_range;
  assign prdata  = out_of_range ? '0 : mem[idx];

  // --------------------------------------------------
  // Wait counter
  // --------------------------------------------------

  // Loaded on the setup edge so it is live from the first access cycle
  always_ff @(posedge pclk) begin
    if (reset) begin
      wait_cnt <= 2'd0;
    end else if (setup) begin
      wait_cnt <= paddr[3:2];
    end else if (access && (wait_cnt != 2'd0)) begin
      wait_cnt <= wait_cnt - 2'd1;
    end
  end

  // --------------------------------------------------
  // Memory
  // --------------------------------------------------

  // Cleared on reset, written in the completing cycle only
  always_ff @(posedge pclk) begin
    if (reset) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (pready && pwrite && !out_of_range) begin
      mem[idx] <= pwdata;
    end
  end

endmodule

`default_nettype wire

//--- apb3_wlm_host.sv
// Single completer, one transfer in flight; responses are one-cycle pulses with no back-pressure
`default_nettype none

`include "apb3_host_settings.svh"

module apb3_wlm_host import apb3_host_pkg::*; (
  input  logic               pclk,
  input  logic               reset,
  apb3_cmd_if.host           cmd,
  output logic [`APB_AW-1:0] paddr,
  output logic               psel,
  output logic               penable,
  output logic               pwrite,
  output logic [`APB_DW-1:0] pwdata,
  input  logic [`APB_DW-1:0] prdata,
  input  logic               pready,
  input  logic               pslverr,
  output logic               rsp_valid,
  output logic               rsp_write,
  output logic               rsp_error,
  output apb_rsp_u           rsp_word
);

  apb_state_e state;
  apb_cmd_t   cur_cmd;
  apb_rsp_u   rsp_next;
  logic       done;

  // --------------------------------------------------
  // Bus drive
  // --------------------------------------------------

  // Pop the head only when idle, so one command is in flight
  assign cmd.take = (state == IDLE) && cmd.valid;

  // Phase strobes come straight from the state
  assign psel    = (state != IDLE);
  assign penable = (state == ACCESS);

  // Address, direction and data held stable from setup to the end
  assign paddr  = cur_cmd.addr;
  assign pwrite = cur_cmd.write;
  assign pwdata = cur_cmd.wdata;

  // Last access cycle
  assign done = (state == ACCESS) && pready;

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------

  always_ff @(posedge pclk) begin
    if (reset) begin
      state     <= IDLE;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (cmd.valid) begin
            state <= SETUP;
          end
        end
        SETUP: begin
          state <= ACCESS;
        end
        ACCESS: begin
          // Wait states keep us here
          if (pready) begin
            state     <= IDLE;
            rsp_valid <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // Response build
  // --------------------------------------------------

  always_comb begin
    rsp_next = '0;
    if (pslverr) begin
      rsp_next.fault.code      = FAULT_RANGE;
      rsp_next.fault.word_addr = cur_cmd.addr[`APB_AW-1:2];
    end else if (cur_cmd.write) begin
      // Writes echo their own data
      rsp_next.data = cur_cmd.wdata;
    end else begin
      rsp_next.data = prdata;
    end
  end

  // Latched command and response payload
  always_ff @(posedge pclk) begin
    if (cmd.take) begin
      cur_cmd <= cmd.cmd;
    end
    if (done) begin
      rsp_write <= cur_cmd.write;
      rsp_error <= pslverr;
      rsp_word  <= rsp_next;
    end
  end

endmodule

`default_nettype wire

//--- apb3_cmd_queue.sv
// A push without a credit is outside the contract and is dropped when full; depth must be >= 2
`default_nettype none

`include "apb3_host_settings.svh"

module apb3_cmd_queue import apb3_host_pkg::*; (
  input  logic     pclk,
  input  logic     reset,
  input  logic     push,
  input  apb_cmd_t push_cmd,
  output logic     credit_return,
  apb3_cmd_if.queue cmd
);

  localparam int unsigned PW = $clog2(`CMD_DEPTH);
  localparam int unsigned CW = $clog2(`CMD_DEPTH + 1);

  // --------------------------------------------------
  // Storage and pointers
  // --------------------------------------------------

  apb_cmd_t        store [`CMD_DEPTH];
  logic [PW-1:0]   wr_ptr;
  logic [PW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            full;
  logic            do_push;
  logic            do_pop;

  assign full    = (count == CW'(`CMD_DEPTH));
  // Guard against a misbehaving source
  assign do_push = push && !full;
  // Host only pops while valid, but keep the FIFO safe anyway
  assign do_pop  = cmd.take && cmd.valid;

  // Head is visible as soon as the count goes nonzero
  assign cmd.valid = (count != '0);
  assign cmd.cmd   = store[rd_ptr];

  // Payload entries carry no reset
  always_ff @(posedge pclk) begin
    if (do_push) begin
      store[wr_ptr] <= push_cmd;
    end
  end

  // --------------------------------------------------
  // Pointer and count control
  // --------------------------------------------------

  always_ff @(posedge pclk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        // Wrap explicitly, depth need not be a power of two
        wr_ptr <= (wr_ptr == PW'(`CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PW'(`CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------------------------------------
  // Credit return
  // --------------------------------------------------

  // One credit per pop, one cycle later
  // Keeps source credits equal to free entries
  always_ff @(posedge pclk) begin
    if (reset) begin
      credit_return <= 1'b0;
    end else begin
      credit_return <= do_pop;
    end
  end

endmodule

`default_nettype wire

//--- apb3_cmd_if.sv
// Pull link with a single consumer; take must only be raised while valid is high
`default_nettype none

`include "apb3_host_settings.svh"

interface apb3_cmd_if import apb3_host_pkg::*; ();

  // --------------------------------------------------
  // Link signals
  // --------------------------------------------------

  // Head of queue present
  logic     valid;

  // Command at the head of the queue
  apb_cmd_t cmd;

  // One cycle pop strobe from the host
  logic     take;

  // --------------------------------------------------
  // Views
  // --------------------------------------------------

  // FIFO side presents the head and sees the pop
  modport queue (
    output valid,
    output cmd,
    input  take
  );

  // Host side watches the head and pops it
  modport host (
    input  valid,
    input  cmd,
    output take
  );

endinterface

`default_nettype wire

//--- apb3_host_pkg.sv
// Types only. The fault view assumes `APB_AW equals `APB_DW so the union views line up
`default_nettype none

`include "apb3_host_settings.svh"

package apb3_host_pkg;

  // --------------------------------------------------
  // Command
  // --------------------------------------------------

  // One queued bus command
  typedef struct packed {
    logic              write;
    logic [`APB_AW-1:0] addr;
    logic [`APB_DW-1:0] wdata;
  } apb_cmd_t;

  // --------------------------------------------------
  // Response
  // --------------------------------------------------

  // Fault code for a word address outside the memory
  localparam logic [1:0] FAULT_RANGE = 2'b01;

  // Fault view layout
  // Code sits in the top two bits, word address below it
  typedef struct packed {
    logic [1:0]         code;
    logic [`APB_DW-3:0] word_addr;
  } apb_fault_t;

  // One response word, read through data or fault
  // rsp_error picks the view
  typedef union packed {
    logic [`APB_DW-1:0] data;
    apb_fault_t         fault;
  } apb_rsp_u;

  // --------------------------------------------------
  // Host FSM
  // --------------------------------------------------

  // Classic APB3 master phases
  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } apb_state_e;

endpackage

`default_nettype wire

//--- apb3_host_settings.svh
// Address and data width must both stay 32 because the response union packs a 30 bit word address
`ifndef APB3_HOST_SETTINGS_SVH
`define APB3_HOST_SETTINGS_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------

// Byte address width of the APB bus
`define APB_AW 32

// Data width of the APB bus
`define APB_DW 32

// --------------------------------------------------
// Sizing
// --------------------------------------------------

// Entries in the command FIFO, also the credits handed out after reset
`define CMD_DEPTH 4

// Words in the completer memory
// Word addresses at or above this give a slave error
`define MEM_WORDS 64

`endif
